// ==== bp_params.svh ====
`ifndef BP_PARAMS_SVH
`define BP_PARAMS_SVH

// program counter width
`define BP_ADDR_WIDTH 32

// global history bits, one non-bias weight per bit
`define BP_HISTORY_LEN 16

// perceptron rows, keep a power of two
`define BP_TABLE_ENTRIES 64

// signed weight width
`define BP_WEIGHT_BITS 8

// floor(1.93 * 16 + 14)
`define BP_THRESHOLD 44

`endif

// ==== mips_core_pkg.sv ====
`include "bp_params.svh"

package mips_core_pkg;

    // resolved or predicted direction of a branch
    typedef enum logic {
        NOT_TAKEN = 1'b0,
        TAKEN     = 1'b1
    } BranchOutcome;

    typedef logic [`BP_ADDR_WIDTH-1:0] addr_t;

endpackage

// ==== perceptron_pkg.sv ====
`include "bp_params.svh"

package perceptron_pkg;

    // one saturating weight
    typedef logic signed [`BP_WEIGHT_BITS-1:0] weight_t;

    // dot product, wide enough for every weight at full scale
    typedef logic signed [31:0] sum_t;

    // row select into the weight table
    typedef logic [$clog2(`BP_TABLE_ENTRIES)-1:0] index_t;

    // bit 0 holds the newest outcome
    typedef logic [`BP_HISTORY_LEN-1:0] history_t;

endpackage

// ==== bp_ifs.sv ====
`timescale 1ns/1ps

// lookup side, answered in the same cycle
interface bp_req_if;

    logic                        valid;
    mips_core_pkg::addr_t        pc;
    mips_core_pkg::BranchOutcome prediction;
    perceptron_pkg::history_t    ghr;

    modport predictor (
        input  valid,
        input  pc,
        input  ghr,
        output prediction
    );

    modport source (
        output valid,
        output pc,
        output ghr,
        input  prediction
    );

endinterface

// resolved branches coming back from the pipeline
interface bp_fb_if;

    logic                        valid;
    mips_core_pkg::addr_t        pc;
    mips_core_pkg::BranchOutcome prediction;
    mips_core_pkg::BranchOutcome outcome;
    perceptron_pkg::history_t    ghr;

    modport trainer (
        input valid,
        input pc,
        input prediction,
        input outcome,
        input ghr
    );

    modport history (
        input  valid,
        input  outcome,
        output ghr
    );

endinterface

// ==== global_history.sv ====
`timescale 1ns/1ps

`include "bp_params.svh"

module global_history (
    input  logic     clk,
    input  logic     rst_n,
    bp_fb_if.history fb
);

    perceptron_pkg::history_t ghr_q;
    perceptron_pkg::history_t ghr_next;
    logic                     taken_bit;

    assign taken_bit = (fb.outcome == mips_core_pkg::TAKEN);

    // newest outcome enters at bit 0, oldest falls off the top
    always_comb begin
        ghr_next = {ghr_q[`BP_HISTORY_LEN-2:0], taken_bit};
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ghr_q <= '0;
        end else if (fb.valid) begin
            ghr_q <= ghr_next;
        end
    end

    assign fb.ghr = ghr_q;

endmodule

// ==== perceptron_predictor.sv ====
`timescale 1ns/1ps

`include "bp_params.svh"

module perceptron_predictor (
    input  logic       clk,
    input  logic       rst_n,
    bp_req_if.predictor req,
    bp_fb_if.trainer    fb
);

    // bias plus one weight per history bit
    localparam int WEIGHT_NUM = `BP_HISTORY_LEN + 1;
    localparam int IDX_BITS   = $bits(perceptron_pkg::index_t);

    localparam perceptron_pkg::weight_t W_MAX = {1'b0, {(`BP_WEIGHT_BITS-1){1'b1}}};
    localparam perceptron_pkg::weight_t W_MIN = {1'b1, {(`BP_WEIGHT_BITS-1){1'b0}}};

    perceptron_pkg::weight_t weights [`BP_TABLE_ENTRIES][WEIGHT_NUM];

    // request path
    perceptron_pkg::index_t  req_idx;
    perceptron_pkg::weight_t req_row [WEIGHT_NUM];
    perceptron_pkg::sum_t    req_sum;

    // feedback path
    perceptron_pkg::index_t  fb_idx;
    perceptron_pkg::weight_t fb_row [WEIGHT_NUM];
    perceptron_pkg::weight_t fb_row_next [WEIGHT_NUM];
    perceptron_pkg::sum_t    fb_sum;
    perceptron_pkg::sum_t    fb_mag;
    logic                    fb_mispredict;
    logic                    fb_low_conf;
    logic                    train_en;
    logic                    fb_taken;

    // word address xor low history, width truncation does the modulo
    function automatic perceptron_pkg::index_t row_index(
        input mips_core_pkg::addr_t     pc,
        input perceptron_pkg::history_t hist
    );
        return pc[IDX_BITS+1:2] ^ hist[IDX_BITS-1:0];
    endfunction

    // bias always sees +1, a history bit of 0 counts as -1
    function automatic perceptron_pkg::sum_t dot_product(
        input perceptron_pkg::weight_t  row [WEIGHT_NUM],
        input perceptron_pkg::history_t hist
    );
        perceptron_pkg::sum_t acc;
        acc = perceptron_pkg::sum_t'(row[0]);
        for (int i = 1; i < WEIGHT_NUM; i++) begin
            if (hist[i-1]) begin
                acc = acc + perceptron_pkg::sum_t'(row[i]);
            end else begin
                acc = acc - perceptron_pkg::sum_t'(row[i]);
            end
        end
        return acc;
    endfunction

    // one step toward agreement, held at the signed limits
    function automatic perceptron_pkg::weight_t train_step(
        input perceptron_pkg::weight_t w,
        input logic                    agree
    );
        if (agree && (w != W_MAX)) begin
            return w + perceptron_pkg::weight_t'(1);
        end else if (!agree && (w != W_MIN)) begin
            return w - perceptron_pkg::weight_t'(1);
        end
        return w;
    endfunction

    // lookup
    assign req_idx = row_index(req.pc, req.ghr);

    always_comb begin
        for (int i = 0; i < WEIGHT_NUM; i++) begin
            req_row[i] = weights[req_idx][i];
        end
    end

    assign req_sum = dot_product(req_row, req.ghr);

    // zero counts as taken
    always_comb begin
        if (req.valid && (req_sum >= 0)) begin
            req.prediction = mips_core_pkg::TAKEN;
        end else begin
            req.prediction = mips_core_pkg::NOT_TAKEN;
        end
    end

    // recompute row and sum from the resolved pc, so nothing is stored per branch
    assign fb_idx = row_index(fb.pc, fb.ghr);

    always_comb begin
        for (int i = 0; i < WEIGHT_NUM; i++) begin
            fb_row[i] = weights[fb_idx][i];
        end
    end

    assign fb_sum   = dot_product(fb_row, fb.ghr);
    assign fb_mag   = (fb_sum < 0) ? -fb_sum : fb_sum;
    assign fb_taken = (fb.outcome == mips_core_pkg::TAKEN);

    assign fb_mispredict = (fb.prediction != fb.outcome);
    assign fb_low_conf   = (fb_mag <= `BP_THRESHOLD);
    assign train_en      = fb.valid && (fb_mispredict || fb_low_conf);

    // input x agrees with the outcome when x == t
    always_comb begin
        logic x_bit;
        for (int i = 0; i < WEIGHT_NUM; i++) begin
            x_bit          = (i == 0) ? 1'b1 : fb.ghr[i-1];
            fb_row_next[i] = train_step(fb_row[i], x_bit == fb_taken);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < `BP_TABLE_ENTRIES; r++) begin
                for (int i = 0; i < WEIGHT_NUM; i++) begin
                    weights[r][i] <= '0;
                end
            end
        end else if (train_en) begin
            for (int i = 0; i < WEIGHT_NUM; i++) begin
                weights[fb_idx][i] <= fb_row_next[i];
            end
        end
    end

endmodule

// ==== branch_predict_unit.sv ====
`timescale 1ns/1ps

module branch_predict_unit (
    input  logic                        clk,
    input  logic                        rst_n,

    input  logic                        i_req_valid,
    input  mips_core_pkg::addr_t        i_req_pc,
    output mips_core_pkg::BranchOutcome o_req_prediction,

    input  logic                        i_fb_valid,
    input  mips_core_pkg::addr_t        i_fb_pc,
    input  mips_core_pkg::BranchOutcome i_fb_prediction,
    input  mips_core_pkg::BranchOutcome i_fb_outcome
);

    bp_req_if req_if ();
    bp_fb_if  fb_if ();

    // request side
    assign req_if.valid     = i_req_valid;
    assign req_if.pc        = i_req_pc;
    assign o_req_prediction = req_if.prediction;

    // lookup uses the same history the history register publishes on feedback
    assign req_if.ghr = fb_if.ghr;

    // feedback side
    assign fb_if.valid      = i_fb_valid;
    assign fb_if.pc         = i_fb_pc;
    assign fb_if.prediction = i_fb_prediction;
    assign fb_if.outcome    = i_fb_outcome;

    global_history u_global_history (
        .clk   (clk),
        .rst_n (rst_n),
        .fb    (fb_if.history)
    );

    perceptron_predictor u_perceptron_predictor (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req_if.predictor),
        .fb    (fb_if.trainer)
    );

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // reset held low for 8 rising edges
    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

// ==== bp_checker.sv ====
`timescale 1ns/1ps

`include "bp_params.svh"

module bp_checker (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        i_req_valid,
    input  mips_core_pkg::addr_t        i_req_pc,
    input  mips_core_pkg::BranchOutcome i_req_prediction,
    input  logic                        i_fb_valid,
    input  mips_core_pkg::addr_t        i_fb_pc,
    input  mips_core_pkg::BranchOutcome i_fb_prediction,
    input  mips_core_pkg::BranchOutcome i_fb_outcome,
    input  logic                        i_exp_check,
    input  logic                        i_exp_prediction,
    output int                          o_model_errors,
    output int                          o_table_errors
);

    localparam int NW = `BP_HISTORY_LEN + 1;

    int         m_w [`BP_TABLE_ENTRIES][NW];
    logic [`BP_HISTORY_LEN-1:0] m_hist;

    function automatic int model_index(input logic [31:0] pc);
        return ((pc >> 2) ^ m_hist) % `BP_TABLE_ENTRIES;
    endfunction

    // bias plus signed votes of each history bit
    function automatic int model_sum(input int row);
        int s;
        s = m_w[row][0];
        for (int k = 0; k < `BP_HISTORY_LEN; k++) begin
            s = m_hist[k] ? s + m_w[row][k+1] : s - m_w[row][k+1];
        end
        return s;
    endfunction

    function automatic logic model_predict(input logic [31:0] pc);
        return model_sum(model_index(pc)) >= 0;
    endfunction

    task automatic model_train(input logic [31:0] pc, input logic pred, input logic taken);
        int row;
        int s;
        int mag;
        int inp;
        row = model_index(pc);
        s   = model_sum(row);
        mag = (s < 0) ? -s : s;
        if (pred != taken || mag <= `BP_THRESHOLD) begin
            for (int k = 0; k < NW; k++) begin
                inp = (k == 0) ? 1 : m_hist[k-1];
                m_w[row][k] = m_w[row][k] + ((inp == taken) ? 1 : -1);
                if (m_w[row][k] > 127) m_w[row][k] = 127;
                if (m_w[row][k] < -128) m_w[row][k] = -128;
            end
        end
        m_hist = {m_hist[`BP_HISTORY_LEN-2:0], taken};
    endtask

    initial begin
        o_model_errors = 0;
        o_table_errors = 0;
    end

    // mid-cycle sample, inputs settled since 1 ns after the edge
    always @(negedge clk) begin
        logic exp_p;
        if (!rst_n) begin
            m_hist = '0;
            for (int r = 0; r < `BP_TABLE_ENTRIES; r++) begin
                for (int k = 0; k < NW; k++) m_w[r][k] = 0;
            end
        end else begin
            if (i_req_valid) begin
                exp_p = model_predict(i_req_pc);
                if (i_req_prediction !== exp_p) begin
                    $display("[FAIL] %0t o_req_prediction expected %0d actual %0d (model)",
                             $time, exp_p, i_req_prediction);
                    o_model_errors = o_model_errors + 1;
                end
                if (i_exp_check && i_req_prediction !== i_exp_prediction) begin
                    $display("[FAIL] %0t o_req_prediction expected %0d actual %0d (table)",
                             $time, i_exp_prediction, i_req_prediction);
                    o_table_errors = o_table_errors + 1;
                end
            end
            if (i_fb_valid) begin
                model_train(i_fb_pc, i_fb_prediction, i_fb_outcome);
            end
        end
    end

endmodule

// ==== branch_predict_tb.sv ====
`timescale 1ns/1ps

module branch_predict_tb;

    logic clk;
    logic rst_n;
    logic req_valid;
    logic [31:0] req_pc;
    mips_core_pkg::BranchOutcome req_pred;
    logic fb_valid;
    logic [31:0] fb_pc;
    logic fb_pred;
    logic fb_out;
    logic exp_check;
    logic exp_pred;
    int model_errors;
    int table_errors;
    int wait_errors;

    // stimulus table, one entry per cycle
    logic        t_rv[$];
    logic [31:0] t_rpc[$];
    logic        t_fv[$];
    logic [31:0] t_fpc[$];
    logic        t_fp[$];
    logic        t_fo[$];
    logic        t_chk[$];
    logic        t_exp[$];

    logic [31:0] pc_set [4] = '{32'h100, 32'h104, 32'h200, 32'h504};

    tb_clock_gen u_clk (.clk(clk), .rst_n(rst_n));

    branch_predict_unit dut (
        .clk              (clk),
        .rst_n            (rst_n),
        .i_req_valid      (req_valid),
        .i_req_pc         (req_pc),
        .o_req_prediction (req_pred),
        .i_fb_valid       (fb_valid),
        .i_fb_pc          (fb_pc),
        .i_fb_prediction  (mips_core_pkg::BranchOutcome'(fb_pred)),
        .i_fb_outcome     (mips_core_pkg::BranchOutcome'(fb_out))
    );

    bp_checker u_chk (
        .clk (clk), .rst_n (rst_n),
        .i_req_valid (req_valid), .i_req_pc (req_pc), .i_req_prediction (req_pred),
        .i_fb_valid (fb_valid), .i_fb_pc (fb_pc),
        .i_fb_prediction (mips_core_pkg::BranchOutcome'(fb_pred)),
        .i_fb_outcome (mips_core_pkg::BranchOutcome'(fb_out)),
        .i_exp_check (exp_check), .i_exp_prediction (exp_pred),
        .o_model_errors (model_errors), .o_table_errors (table_errors)
    );

    task automatic add_row(input logic rv, input logic [31:0] rpc, input logic fv,
                           input logic [31:0] fpc, input logic fp, input logic fo,
                           input logic chk, input logic ex);
        t_rv.push_back(rv);
        t_rpc.push_back(rpc);
        t_fv.push_back(fv);
        t_fpc.push_back(fpc);
        t_fp.push_back(fp);
        t_fo.push_back(fo);
        t_chk.push_back(chk);
        t_exp.push_back(ex);
    endtask

    task automatic drive(input logic rv, input logic [31:0] rpc, input logic fv,
                         input logic [31:0] fpc, input logic fp, input logic fo,
                         input logic chk, input logic ex);
        @(posedge clk);
        #1;
        req_valid = rv;
        req_pc    = rpc;
        fb_valid  = fv;
        fb_pc     = fpc;
        fb_pred   = fp;
        fb_out    = fo;
        exp_check = chk;
        exp_pred  = ex;
    endtask

    task automatic build_table();
        // fresh table predicts taken everywhere
        add_row(1, 32'h100, 0, 0, 0, 0, 1, 1);
        add_row(1, 32'h104, 0, 0, 0, 0, 1, 1);
        add_row(1, 32'h200, 0, 0, 0, 0, 1, 1);
        // request beside feedback still sees the old weights
        add_row(1, 32'h100, 1, 32'h100, 1, 0, 1, 1);
        // bias -1, history weights +1, sum -17
        add_row(1, 32'h100, 0, 0, 0, 0, 1, 0);
        // history 1 moves pc 0x100 to row 1
        add_row(0, 0, 1, 32'h504, 1, 1, 0, 0);
        add_row(1, 32'h100, 0, 0, 0, 0, 1, 1);
        // confidence build, threshold stops training with row 63 at sum 48
        for (int i = 0; i < 80; i++) begin
            add_row(1, 32'h200, 1, 32'h200, 1, 1, 0, 0);
        end
        // not-taken steps on row 63, each one subtracts 17 from the sum
        // 16 taken outcomes at pc 0x10c bring the history back to all ones
        for (int s = 0; s < 6; s++) begin
            add_row(1, 32'h200, 1, 32'h200, 1, 0, 1, (s < 3));
            for (int j = 0; j < 16; j++) begin
                add_row(0, 0, 1, 32'h10c, 1, 1, 0, 0);
            end
        end
        add_row(1, 32'h200, 0, 0, 0, 0, 1, 0);
        // mispredict training toward saturation
        for (int i = 0; i < 200; i++) begin
            add_row(1, 32'h300, 1, 32'h300, 0, 1, 0, 0);
        end
        for (int i = 0; i < 200; i++) begin
            add_row(1, 32'h300, 1, 32'h300, 1, 0, 0, 0);
        end
    endtask

    initial begin
        int cnt;
        logic [31:0] pc;
        req_valid = 0;
        req_pc = 0;
        fb_valid = 0;
        fb_pc = 0;
        fb_pred = 0;
        fb_out = 0;
        exp_check = 0;
        exp_pred = 0;
        wait_errors = 0;
        void'($urandom(9));
        build_table();
        cnt = 0;
        while (rst_n !== 1'b1 && cnt < 20) begin
            @(posedge clk);
            cnt++;
        end
        if (rst_n !== 1'b1) begin
            $display("reset was never released");
            wait_errors++;
        end
        for (int i = 0; i < t_rv.size(); i++) begin
            drive(t_rv[i], t_rpc[i], t_fv[i], t_fpc[i], t_fp[i], t_fo[i], t_chk[i], t_exp[i]);
        end
        for (int i = 0; i < 400; i++) begin
            pc = pc_set[2'($urandom % 4)];
            drive(1'($urandom % 2), pc_set[2'($urandom % 4)], 1'($urandom % 2), pc,
                  u_chk.model_predict(pc), 1'($urandom % 2), 0, 0);
        end
        drive(0, 0, 0, 0, 0, 0, 0, 0);
        @(posedge clk);
        $display("errors: model %0d table %0d wait %0d", model_errors, table_errors,
                 wait_errors);
        if (model_errors == 0 && table_errors == 0 && wait_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(100 * 5000);
        $display("simulation ran too long and was stopped");
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+.
mips_core_pkg.sv
perceptron_pkg.sv
bp_ifs.sv
global_history.sv
perceptron_predictor.sv
branch_predict_unit.sv
tb_clock_gen.sv
bp_checker.sv
branch_predict_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run with Verilator, fail status if the log holds the fail message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module branch_predict_tb -f src.f -o sim_bp \
    && ./obj_dir/sim_bp > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }

cat sim.log
grep -q "RESULT: FAIL" sim.log && exit 1 || exit 0
